// File: Makefile
TOP = fetch_mux_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o $(TOP)_sim
	./obj_dir/$(TOP)_sim | tee sim.log
	grep -qx "=== PASS ===" sim.log

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)
	verilator --lint-only --timing --assert -f sim.f --top-module fetch_mux_top

clean:
	rm -rf obj_dir sim.log

// File: rtl/fetch_mux_defines.svh
`ifndef FETCH_MUX_DEFINES_SVH
`define FETCH_MUX_DEFINES_SVH

// ==========================================================================
// Widths of the instruction-mux stage
// ==========================================================================

// One fetched cache line, 64 bytes
`define LINE_W 512

// Aligned window that holds the four slot instructions
`define WIN_W 192

// Fixed instruction width, three parcels
`define INS_W 48

`define PC_W 32

// Alignment granule of the instruction stream
`define PARCEL_W 16

// Number of instructions in one pipeline group
`define SLOTS 4

// Byte distance between the PCs of neighbouring slots
`define INS_BYTES 6

// Reset vector, also the default target and return PC
`define RST_PC 32'hFFFC_0100

`endif

// File: rtl/fetch_mux_pkg.sv
`include "fetch_mux_defines.svh"

package fetch_mux_pkg;

	// ======================================================================
	// Plain vector types
	// ======================================================================

	typedef logic [`PC_W-1:0] pc_t;
	typedef logic [`LINE_W-1:0] cline_t;
	typedef logic [`WIN_W-1:0] window_t;
	typedef logic [`INS_W-1:0] ins_t;

	// Interrupt priority level as carried in the group header
	typedef logic [5:0] ipl_t;

	// ======================================================================
	// Instruction encoding
	// ======================================================================

	// The opcode sits in bits 6:0 of every instruction
	// A zero parcel decodes as a NOP so that padding and reset values agree
	typedef enum logic [6:0] {
		OP_NOP = 7'h00,
		OP_ALU = 7'h04,
		OP_BSR = 7'h20,
		OP_RET = 7'h21,
		OP_BCC = 7'h28
	} opcode_e;

	// ======================================================================
	// Pipeline group
	// ======================================================================

	// One registered slot of the group
	typedef struct packed {
		ins_t ins;
		pc_t  pc;
		// Slot holds an instruction that may execute
		logic v;
		// Slot was emptied by single-step mode
		logic ssm;
		// Branch predicted taken for this slot
		logic bt;
	} slot_t;

	// Slot 0 is the lowest element and comes first in program order
	typedef slot_t [`SLOTS-1:0] group_t;

	// Per-slot control masks computed ahead of the slot registers
	typedef struct packed {
		logic [`SLOTS-1:0] v;
		logic [`SLOTS-1:0] ssm;
		logic [`SLOTS-1:0] nop;
	} slot_ctl_t;

	// PC of a slot inside the group starting at pc0
	function automatic pc_t fn_slot_pc(pc_t pc0, int unsigned idx);
		return pc0 + pc_t'(`INS_BYTES * idx);
	endfunction

endpackage

// File: rtl/fetch_mux_top.sv
`timescale 1ns/1ps
`include "fetch_mux_defines.svh"

module fetch_mux_top (
	input  logic                     clk,
	input  logic                     rst_i,
	input  fetch_mux_pkg::cline_t    cline_i,
	input  fetch_mux_pkg::pc_t       pc0_i,
	input  logic [`SLOTS-1:0]        takb_i,
	input  logic                     en_i,
	input  logic                     stall_i,
	input  logic                     ssm_i,
	input  logic                     irq_i,
	input  fetch_mux_pkg::ipl_t      ipl_i,
	input  logic                     stomp_i,
	input  logic                     branchmiss_i,
	input  fetch_mux_pkg::pc_t       miss_pc_i,
	output fetch_mux_pkg::group_t    group_o,
	output logic                     do_call_o,
	output logic                     do_branch_o,
	output logic                     do_ret_o,
	output fetch_mux_pkg::pc_t       tgt_o,
	output fetch_mux_pkg::pc_t       ret_pc_o,
	output logic                     hwi_o,
	output fetch_mux_pkg::ipl_t      ipl_o,
	output logic                     nop_o
);
	import fetch_mux_pkg::*;

	window_t window;
	logic redundant;
	logic stage_en;
	slot_ctl_t ctl;

	// ======================================================================
	// Alignment and control
	// ======================================================================

	line_align u_align (
		.clk         (clk),
		.rst_i       (rst_i),
		.stage_en_i  (stage_en),
		.cline_i     (cline_i),
		.pc0_i       (pc0_i),
		.window_o    (window),
		.redundant_o (redundant)
	);

	mux_ctrl u_ctrl (
		.clk          (clk),
		.rst_i        (rst_i),
		.en_i         (en_i),
		.stall_i      (stall_i),
		.ssm_i        (ssm_i),
		.irq_i        (irq_i),
		.stomp_i      (stomp_i),
		.branchmiss_i (branchmiss_i),
		.redundant_i  (redundant),
		.pc0_i        (pc0_i),
		.miss_pc_i    (miss_pc_i),
		.ipl_i        (ipl_i),
		.stage_en_o   (stage_en),
		.ctl_o        (ctl),
		.hwi_o        (hwi_o),
		.ipl_o        (ipl_o),
		.nop_o        (nop_o)
	);

	// ======================================================================
	// Slot registers and flow detection
	// ======================================================================

	// Each slot takes its own 48-bit field of the aligned window
	for (genvar g = 0; g < `SLOTS; g++) begin : g_slot
		slot_reg u_slot (
			.clk        (clk),
			.rst_i      (rst_i),
			.stage_en_i (stage_en),
			.valid_i    (ctl.v[g]),
			.ssm_i      (ctl.ssm[g]),
			.nop_i      (ctl.nop[g]),
			.takb_i     (takb_i[g]),
			.ins_i      (window[g*`INS_W +: `INS_W]),
			.pc_i       (fn_slot_pc(pc0_i, g)),
			.slot_o     (group_o[g])
		);
	end

	flow_detect u_flow (
		.group_i     (group_o),
		.stomp_i     (stomp_i),
		.do_call_o   (do_call_o),
		.do_branch_o (do_branch_o),
		.do_ret_o    (do_ret_o),
		.tgt_o       (tgt_o),
		.ret_pc_o    (ret_pc_o)
	);

endmodule

// File: rtl/flow_detect.sv
`timescale 1ns/1ps
`include "fetch_mux_defines.svh"

module flow_detect (
	input  fetch_mux_pkg::group_t group_i,
	input  logic                  stomp_i,
	output logic                  do_call_o,
	output logic                  do_branch_o,
	output logic                  do_ret_o,
	output fetch_mux_pkg::pc_t    tgt_o,
	output fetch_mux_pkg::pc_t    ret_pc_o
);
	import fetch_mux_pkg::*;

	// Signed displacement field in bits 47:24
	localparam int DISP_LSB = 24;
	localparam int DISP_W = 24;

	logic [`SLOTS-1:0] is_call;
	logic [`SLOTS-1:0] is_bcc;
	logic [`SLOTS-1:0] is_ret;
	pc_t slot_tgt [`SLOTS];

	// ======================================================================
	// Per-slot decode
	// ======================================================================

	always_comb begin
		for (int i = 0; i < `SLOTS; i++) begin
			is_call[i] = group_i[i].ins[6:0] == OP_BSR;
			is_bcc[i] = group_i[i].ins[6:0] == OP_BCC;
			is_ret[i] = group_i[i].ins[6:0] == OP_RET;
			// PC-relative target, displacement sign-extended to PC width
			slot_tgt[i] = group_i[i].pc + {{(`PC_W-DISP_W){group_i[i].ins[DISP_LSB+DISP_W-1]}},
				group_i[i].ins[DISP_LSB +: DISP_W]};
		end
	end

	// ======================================================================
	// First change of flow in slot order
	// ======================================================================

	always_comb begin
		do_call_o = 1'b0;
		do_branch_o = 1'b0;
		do_ret_o = 1'b0;
		for (int i = `SLOTS - 1; i >= 0; i--) begin
			// Walking down from slot 3 lets the earliest slot win
			if (is_call[i] || is_bcc[i]) begin
				do_branch_o = 1'b1;
				do_call_o = is_call[i];
				do_ret_o = 1'b0;
			end else if (is_ret[i]) begin
				do_branch_o = 1'b0;
				do_call_o = 1'b0;
				do_ret_o = 1'b1;
			end
		end
		// A stomped group must not redirect fetch
		if (stomp_i) begin
			do_call_o = 1'b0;
			do_branch_o = 1'b0;
			do_ret_o = 1'b0;
		end
	end

	// Target of the first call or branch, returns do not block it
	always_comb begin
		tgt_o = `RST_PC;
		for (int i = `SLOTS - 1; i >= 0; i--)
			if (is_call[i] || is_bcc[i])
				tgt_o = slot_tgt[i];
	end

	// Return address of the first call in the group
	always_comb begin
		ret_pc_o = `RST_PC;
		for (int i = `SLOTS - 1; i >= 0; i--)
			if (is_call[i])
				ret_pc_o = group_i[i].pc + pc_t'(`INS_BYTES);
	end

	always_comb begin
		a_call_ret_excl: assert (!(do_call_o && do_ret_o))
			else $error("flow_detect: call and return flagged together");
	end

endmodule

// File: rtl/line_align.sv
`timescale 1ns/1ps
`include "fetch_mux_defines.svh"

module line_align (
	input  logic                     clk,
	input  logic                     rst_i,
	input  logic                     stage_en_i,
	input  fetch_mux_pkg::cline_t    cline_i,
	input  fetch_mux_pkg::pc_t       pc0_i,
	output fetch_mux_pkg::window_t   window_o,
	output logic                     redundant_o
);
	import fetch_mux_pkg::*;

	// Number of parcels appended above the line so a group that runs off
	// the end still reads defined NOP parcels
	localparam int PAD_PARCELS = `WIN_W / `PARCEL_W;

	logic [`PARCEL_W-1:0] nop_parcel;
	logic [`LINE_W+`WIN_W-1:0] ext_line;
	logic [`LINE_W+`WIN_W-1:0] shifted;
	window_t prev_window;
	pc_t prev_pc;

	assign nop_parcel = `PARCEL_W'(OP_NOP);

	// ======================================================================
	// Alignment on the group PC
	// ======================================================================

	assign ext_line = {{PAD_PARCELS{nop_parcel}}, cline_i};

	// PC bits 5:1 give the parcel index inside the 64-byte line
	assign shifted = ext_line >> {pc0_i[5:1], 4'd0};
	assign window_o = shifted[`WIN_W-1:0];

	// ======================================================================
	// Redundant group detection
	// ======================================================================

	// Remember the last group accepted by the stage
	always_ff @(posedge clk) begin
		if (rst_i) begin
			prev_window <= '0;
			prev_pc <= '0;
		end else if (stage_en_i) begin
			prev_window <= window_o;
			prev_pc <= pc0_i;
		end
	end

	// Same PC and same aligned bits means fetch is replaying a group
	assign redundant_o = (prev_pc == pc0_i) && (prev_window == window_o);

	a_window_known: assert property (
		@(posedge clk) disable iff (rst_i) !$isunknown(window_o)
	) else $error("line_align: aligned window holds unknown bits");

endmodule

// File: rtl/mux_ctrl.sv
`timescale 1ns/1ps
`include "fetch_mux_defines.svh"

module mux_ctrl (
	input  logic                      clk,
	input  logic                      rst_i,
	input  logic                      en_i,
	input  logic                      stall_i,
	input  logic                      ssm_i,
	input  logic                      irq_i,
	input  logic                      stomp_i,
	input  logic                      branchmiss_i,
	input  logic                      redundant_i,
	input  fetch_mux_pkg::pc_t        pc0_i,
	input  fetch_mux_pkg::pc_t        miss_pc_i,
	input  fetch_mux_pkg::ipl_t       ipl_i,
	output logic                      stage_en_o,
	output fetch_mux_pkg::slot_ctl_t  ctl_o,
	output logic                      hwi_o,
	output fetch_mux_pkg::ipl_t       ipl_o,
	output logic                      nop_o
);
	import fetch_mux_pkg::*;

	logic prev_ssm;
	logic ssm_first;
	logic ssm_cont;
	logic [`SLOTS-1:0] miss_nop;

	// The stage advances only when fetch offers a group and decode can take it
	assign stage_en_o = en_i & ~stall_i;

	// ======================================================================
	// Single-step history
	// ======================================================================

	always_ff @(posedge clk) begin
		if (rst_i)
			prev_ssm <= 1'b0;
		else if (stage_en_o)
			prev_ssm <= ssm_i;
	end

	// First group of a single-step run lets one instruction through
	assign ssm_first = ssm_i & ~prev_ssm;
	assign ssm_cont = ssm_i & prev_ssm;

	// ======================================================================
	// Slot masks
	// ======================================================================

	// Slots that lie before the miss PC were already executed on the
	// correct path, so they must not run again
	always_comb begin
		for (int i = 0; i < `SLOTS; i++)
			miss_nop[i] = branchmiss_i && (fn_slot_pc(pc0_i, i) < miss_pc_i);
	end

	always_comb begin
		ctl_o = '0;
		for (int i = 0; i < `SLOTS; i++) begin
			// Only slot 0 survives the first single-step cycle
			if (i == 0)
				ctl_o.v[i] = ~irq_i & ~stomp_i & ~ssm_cont;
			else
				ctl_o.v[i] = ~irq_i & ~stomp_i & ~ssm_i;

			// A replayed group is dropped outright and carries no ssm marks
			if (redundant_i) begin
				ctl_o.ssm[i] = 1'b0;
				ctl_o.nop[i] = 1'b1;
			end else if (ssm_first) begin
				ctl_o.ssm[i] = (i != 0);
				ctl_o.nop[i] = (i != 0) | miss_nop[i];
			end else if (ssm_cont) begin
				ctl_o.ssm[i] = 1'b1;
				ctl_o.nop[i] = 1'b1;
			end else begin
				ctl_o.ssm[i] = 1'b0;
				ctl_o.nop[i] = miss_nop[i];
			end
		end
	end

	// ======================================================================
	// Group header
	// ======================================================================

	// Priority level travels with the group it was sampled for
	always_ff @(posedge clk) begin
		if (rst_i) begin
			hwi_o <= 1'b0;
			ipl_o <= '0;
			nop_o <= 1'b0;
		end else if (stage_en_o) begin
			hwi_o <= irq_i;
			ipl_o <= ipl_i;
			nop_o <= stomp_i;
		end
	end

	// A slot emptied by single-step mode is never valid and always loads a NOP
	a_ssm_slot_empty: assert property (
		@(posedge clk) disable iff (rst_i)
		((ctl_o.ssm & ctl_o.v) == '0) && ((ctl_o.ssm & ~ctl_o.nop) == '0)
	) else $error("mux_ctrl: single-step slot left valid or loaded");

endmodule

// File: rtl/slot_reg.sv
`timescale 1ns/1ps
`include "fetch_mux_defines.svh"

module slot_reg (
	input  logic                 clk,
	input  logic                 rst_i,
	input  logic                 stage_en_i,
	input  logic                 valid_i,
	input  logic                 ssm_i,
	input  logic                 nop_i,
	input  logic                 takb_i,
	input  fetch_mux_pkg::ins_t  ins_i,
	input  fetch_mux_pkg::pc_t   pc_i,
	output fetch_mux_pkg::slot_t slot_o
);
	import fetch_mux_pkg::*;

	ins_t nop_ins;
	ins_t ins_sel;

	// A NOP is the opcode alone with every other field zero
	assign nop_ins = ins_t'(OP_NOP);

	// Emptied slots keep their PC so later stages still see program order
	assign ins_sel = nop_i ? nop_ins : ins_i;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			slot_o.ins <= nop_ins;
			slot_o.pc <= `RST_PC;
			slot_o.v <= 1'b0;
			slot_o.ssm <= 1'b0;
			slot_o.bt <= 1'b0;
		end else if (stage_en_i) begin
			slot_o.ins <= ins_sel;
			slot_o.pc <= pc_i;
			slot_o.v <= valid_i;
			slot_o.ssm <= ssm_i;
			// Prediction bit from fetch rides along unchanged
			slot_o.bt <= takb_i;
		end
	end

endmodule

// File: sim.f
+incdir+rtl
rtl/fetch_mux_pkg.sv
rtl/line_align.sv
rtl/mux_ctrl.sv
rtl/slot_reg.sv
rtl/flow_detect.sv
rtl/fetch_mux_top.sv
tests/fetch_mux_tb.sv

// File: tests/fetch_mux_stimulus.txt
# pc ins0 ins1 ins2 ins3 takb flags ipl miss_pc, then expected: valid ssm nop flow tgt ret_pc hdr
# flags 1 stall 2 ssm 4 irq 8 stomp 10 miss 20 en off, flow {call,branch,ret}, hdr {hwi,nop}

# Extraction at several parcel offsets
1000 111111000004 222222000004 333333000004 444444000004 0 00 00 0 f 0 0 0 fffc0100 fffc0100 0
200a 555555000004 666666000004 777777000004 888888000004 5 00 03 0 f 0 0 0 fffc0100 fffc0100 0
3028 999999000004 aaaaaa000004 bbbbbb000004 cccccc000004 a 00 15 0 f 0 0 0 fffc0100 fffc0100 0
4014 123456000004 234567000004 345678000004 456789000004 f 00 3f 0 f 0 0 0 fffc0100 fffc0100 0

# Call, branch and return priority
5000 0a0a0a000004 000100000020 000000000021 000040000028 0 00 01 0 f 0 0 6 5106 500c 0
6002 0b0b0b000004 000000000021 000020000020 000040000028 2 00 02 0 f 0 0 1 602e 6014 0
7010 ffffc0000028 000080000020 0c0c0c000004 000000000021 1 00 04 0 f 0 0 2 6fd0 701c 0
8000 0d0d0d000004 0e0e0e000004 0f0f0f000004 000000000021 0 00 05 0 f 0 0 1 fffc0100 fffc0100 0
9000 000010000020 101010000004 202020000004 303030000004 0 08 06 0 0 0 0 0 9010 9006 1

# Single-step over three groups, then back to normal
a000 000030000020 404040000004 000020000028 505050000004 0 02 07 0 1 e e 6 a030 a006 0
a006 606060000004 707070000004 808080000004 909090000004 0 02 08 0 0 f f 0 fffc0100 fffc0100 0
a00c a0a0a0000004 b0b0b0000004 c0c0c0000004 000040000020 0 02 09 0 0 f f 0 fffc0100 fffc0100 0
b000 c1c1c1000004 d1d1d1000004 e1e1e1000004 f1f1f1000004 0 00 0a 0 f 0 0 0 fffc0100 fffc0100 0

# Interrupt and branch miss
c000 121212000004 131313000004 141414000004 151515000004 0 04 1f 0 0 0 0 0 fffc0100 fffc0100 2
d000 000100000020 000000000021 131313000004 000008000020 0 10 0b d00c f 0 3 6 d01a d018 0
e000 000000000021 000010000028 141414000004 151515000004 0 10 0c e004 f 0 1 2 e016 fffc0100 0
2200 161616000004 000000000021 171717000004 181818000004 0 10 0d 2000 f 0 0 1 fffc0100 fffc0100 0

# Redundant group, stall and disabled cycles
f008 191919000004 1a1a1a000004 1b1b1b000004 1c1c1c000004 3 00 0e 0 f 0 0 0 fffc0100 fffc0100 0
f008 191919000004 1a1a1a000004 1b1b1b000004 1c1c1c000004 3 00 0e 0 f 0 f 0 fffc0100 fffc0100 0
f010 000020000028 1d1d1d000004 1e1e1e000004 1f1f1f000004 1 00 10 0 f 0 0 2 f030 fffc0100 0
1100 2a2a2a000004 2b2b2b000004 000040000020 000000000021 0 01 11 0 f 0 0 2 f030 fffc0100 0
1200 2f2f2f000004 3a3a3a000004 3b3b3b000004 3c3c3c000004 0 20 12 0 f 0 0 2 f030 fffc0100 0
1100 2a2a2a000004 2b2b2b000004 000040000020 000000000021 0 00 11 0 f 0 0 6 114c 1112 0
1206 000000000021 2c2c2c000004 2d2d2d000004 2e2e2e000004 0 0c 13 0 0 0 0 0 fffc0100 fffc0100 3
1206 000000000021 2c2c2c000004 2d2d2d000004 2e2e2e000004 0 00 13 0 f 0 f 0 fffc0100 fffc0100 0

// File: tests/fetch_mux_tb.sv
`timescale 1ns/1ps
`include "fetch_mux_defines.svh"

module fetch_mux_tb;
	import fetch_mux_pkg::*;

	// Bit positions in the flags column of the stimulus file
	localparam int FLG_STALL = 0;
	localparam int FLG_SSM = 1;
	localparam int FLG_IRQ = 2;
	localparam int FLG_STOMP = 3;
	localparam int FLG_MISS = 4;
	localparam int FLG_EN_OFF = 5;

	// One test vector with its expected results
	typedef struct packed {
		pc_t pc;
		ins_t [`SLOTS-1:0] ins;
		logic [`SLOTS-1:0] takb;
		logic [7:0] flags;
		ipl_t ipl;
		pc_t miss_pc;
		logic [`SLOTS-1:0] exp_v;
		logic [`SLOTS-1:0] exp_ssm;
		logic [`SLOTS-1:0] exp_nop;
		// Order is call, branch, return
		logic [2:0] exp_flow;
		pc_t exp_tgt;
		pc_t exp_ret;
		// Order is hwi, nop
		logic [1:0] exp_hdr;
	} vec_t;

	logic clk;
	logic rst;
	cline_t cline;
	pc_t pc0;
	logic [`SLOTS-1:0] takb;
	logic en;
	logic stall;
	logic ssm;
	logic irq;
	ipl_t ipl;
	logic stomp;
	logic branchmiss;
	pc_t miss_pc;
	group_t group_q;
	logic do_call;
	logic do_branch;
	logic do_ret;
	pc_t tgt;
	pc_t ret_pc;
	logic hwi;
	ipl_t ipl_q;
	logic nop_flag;

	vec_t vecs[$];
	int errors;
	int checks;
	logic loaded;

	// Group and header the DUT should hold after the last accepted vector
	group_t last_group;
	logic [1:0] last_hdr;
	ipl_t last_ipl;

	fetch_mux_top DUT (
		.clk          (clk),
		.rst_i        (rst),
		.cline_i      (cline),
		.pc0_i        (pc0),
		.takb_i       (takb),
		.en_i         (en),
		.stall_i      (stall),
		.ssm_i        (ssm),
		.irq_i        (irq),
		.ipl_i        (ipl),
		.stomp_i      (stomp),
		.branchmiss_i (branchmiss),
		.miss_pc_i    (miss_pc),
		.group_o      (group_q),
		.do_call_o    (do_call),
		.do_branch_o  (do_branch),
		.do_ret_o     (do_ret),
		.tgt_o        (tgt),
		.ret_pc_o     (ret_pc),
		.hwi_o        (hwi),
		.ipl_o        (ipl_q),
		.nop_o        (nop_flag)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// ======================================================================
	// Stimulus helpers
	// ======================================================================

	// Lines that do not hold all sixteen columns are comments or blank
	task automatic load_vectors();
		int fd;
		int n;
		string line;
		vec_t v;
		pc_t pc_r;
		pc_t miss_r;
		pc_t tgt_r;
		pc_t ret_r;
		ins_t i0;
		ins_t i1;
		ins_t i2;
		ins_t i3;
		logic [31:0] takb_r;
		logic [31:0] flags_r;
		logic [31:0] ipl_r;
		logic [31:0] v_r;
		logic [31:0] ssm_r;
		logic [31:0] nop_r;
		logic [31:0] flow_r;
		logic [31:0] hdr_r;
		fd = $fopen("tests/fetch_mux_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Error: the stimulus file could not be opened");
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				pc_r, i0, i1, i2, i3, takb_r, flags_r, ipl_r, miss_r,
				v_r, ssm_r, nop_r, flow_r, tgt_r, ret_r, hdr_r);
			if (n == 16) begin
				v.pc = pc_r;
				v.ins = {i3, i2, i1, i0};
				v.takb = takb_r[`SLOTS-1:0];
				v.flags = flags_r[7:0];
				v.ipl = ipl_r[5:0];
				v.miss_pc = miss_r;
				v.exp_v = v_r[`SLOTS-1:0];
				v.exp_ssm = ssm_r[`SLOTS-1:0];
				v.exp_nop = nop_r[`SLOTS-1:0];
				v.exp_flow = flow_r[2:0];
				v.exp_tgt = tgt_r;
				v.exp_ret = ret_r;
				v.exp_hdr = hdr_r[1:0];
				vecs.push_back(v);
			end
		end
		$fclose(fd);
	endtask

	// Random parcels everywhere with the four instructions laid over them at the PC's parcel
	function automatic cline_t build_line(input pc_t pc, input logic [`WIN_W-1:0] ins);
		cline_t cl;
		cline_t mask;
		int idx;
		for (int p = 0; p < `LINE_W / `PARCEL_W; p++)
			cl[p*`PARCEL_W +: `PARCEL_W] = `PARCEL_W'($urandom);
		idx = int'(pc[5:1]);
		mask = cline_t'({`WIN_W{1'b1}}) << (idx * `PARCEL_W);
		cl = (cl & ~mask) | (cline_t'(ins) << (idx * `PARCEL_W));
		return cl;
	endfunction

	task automatic drive_vector(input vec_t v);
		cline = build_line(v.pc, v.ins);
		pc0 = v.pc;
		takb = v.takb;
		en = !v.flags[FLG_EN_OFF];
		stall = v.flags[FLG_STALL];
		ssm = v.flags[FLG_SSM];
		irq = v.flags[FLG_IRQ];
		stomp = v.flags[FLG_STOMP];
		branchmiss = v.flags[FLG_MISS];
		ipl = v.ipl;
		miss_pc = v.miss_pc;
	endtask

	// ======================================================================
	// Checking
	// ======================================================================

	task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic check_reset();
		for (int s = 0; s < `SLOTS; s++) begin
			check_val(64'(group_q[s].ins), 64'(ins_t'(OP_NOP)), "reset slot instruction");
			check_val(64'(group_q[s].pc), 64'(`RST_PC), "reset slot pc");
			check_val(64'({group_q[s].v, group_q[s].ssm, group_q[s].bt}), 64'(0),
				"reset slot flags");
		end
		check_val(64'({do_call, do_branch, do_ret, hwi, nop_flag}), 64'(0), "reset outputs");
		check_val(64'(ipl_q), 64'(0), "reset ipl");
	endtask

	// A stalled or disabled vector must leave the previous group in place
	task automatic check_vector(input int k, input vec_t v);
		slot_t exp_slot;
		string tag;
		logic freeze;
		freeze = v.flags[FLG_STALL] | v.flags[FLG_EN_OFF];
		for (int s = 0; s < `SLOTS; s++) begin
			if (freeze) begin
				exp_slot = last_group[s];
			end else begin
				exp_slot.ins = v.exp_nop[s] ? ins_t'(OP_NOP) : v.ins[s];
				exp_slot.pc = v.pc + pc_t'(`INS_BYTES * s);
				exp_slot.v = v.exp_v[s];
				exp_slot.ssm = v.exp_ssm[s];
				exp_slot.bt = v.takb[s];
				last_group[s] = exp_slot;
			end
			tag = $sformatf("vector %0d slot %0d", k, s);
			check_val(64'(group_q[s].ins), 64'(exp_slot.ins), {tag, " instruction"});
			check_val(64'(group_q[s].pc), 64'(exp_slot.pc), {tag, " pc"});
			check_val(64'(group_q[s].v), 64'(exp_slot.v), {tag, " valid"});
			check_val(64'(group_q[s].ssm), 64'(exp_slot.ssm), {tag, " ssm"});
			check_val(64'(group_q[s].bt), 64'(exp_slot.bt), {tag, " taken"});
		end
		if (!freeze) begin
			last_hdr = v.exp_hdr;
			last_ipl = v.ipl;
		end
		tag = $sformatf("vector %0d", k);
		check_val(64'({do_call, do_branch, do_ret}), 64'(v.exp_flow), {tag, " flow flags"});
		check_val(64'(tgt), 64'(v.exp_tgt), {tag, " target"});
		check_val(64'(ret_pc), 64'(v.exp_ret), {tag, " return pc"});
		check_val(64'({hwi, nop_flag}), 64'(last_hdr), {tag, " header"});
		check_val(64'(ipl_q), 64'(last_ipl), {tag, " ipl"});
	endtask

	// Each vector takes two cycles and the second one runs with en low
	task automatic run_vector(input int k, input vec_t v);
		@(posedge clk);
		#1;
		drive_vector(v);
		@(posedge clk);
		#1;
		// The other inputs stay put so stomp still gates the flow outputs
		en = 1'b0;
		@(negedge clk);
		check_vector(k, v);
	endtask

	// ======================================================================
	// Main sequence and watchdog
	// ======================================================================

	initial begin
		void'($urandom(32'h68151be2));
		errors = 0;
		checks = 0;
		loaded = 1'b0;
		rst = 1'b1;
		cline = '0;
		pc0 = '0;
		takb = '0;
		en = 1'b0;
		stall = 1'b0;
		ssm = 1'b0;
		irq = 1'b0;
		ipl = '0;
		stomp = 1'b0;
		branchmiss = 1'b0;
		miss_pc = '0;
		// Reset state of the group as the stage defines it
		for (int s = 0; s < `SLOTS; s++) begin
			last_group[s].ins = ins_t'(OP_NOP);
			last_group[s].pc = `RST_PC;
			last_group[s].v = 1'b0;
			last_group[s].ssm = 1'b0;
			last_group[s].bt = 1'b0;
		end
		last_hdr = 2'b00;
		last_ipl = '0;
		load_vectors();
		loaded = 1'b1;
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		check_reset();
		if (vecs.size() == 0) begin
			$display("Error: no test vectors were read from the stimulus file");
			errors++;
		end
		foreach (vecs[k])
			run_vector(k, vecs[k]);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// Twenty cycles per vector plus the reset phase
	initial begin
		int limit;
		wait (loaded);
		limit = (vecs.size() * 20 + 20) * 10;
		#(limit);
		$display("Timeout: the test did not finish within %0d ns", limit);
		$display("=== FAIL ===");
		$finish;
	end

endmodule
